// ==== logic/led_settings.svh ====
`ifndef LED_SETTINGS_SVH
`define LED_SETTINGS_SVH

// system bus geometry
// address and data share one width
`define SB_DATA_W 32

// LED bank
`define LED_COUNT 16

// blink half period in clock cycles
// a board build runs this at 10_000_000
// simulation keeps it short so a full blink period fits in a few dozen cycles
`define LED_BLINK_HALF 8

// register byte offsets of the peripheral
`define LED_VAL_ADDR  32'h0000_0000
`define LED_MODE_ADDR 32'h0000_0004
`define LED_RST_ADDR  32'h0000_0024

`endif

// ==== logic/sb_pkg.sv ====
`include "led_settings.svh"

package sb_pkg;

  // byte address on the system bus
  typedef logic [`SB_DATA_W-1:0] sb_addr_t;

  // write and read data words
  typedef logic [`SB_DATA_W-1:0] sb_data_t;

  // one single-cycle request from the core
  // req acts as valid and the peripheral is always ready
  typedef struct packed {
    logic     req;    // request strobe
    logic     we;     // 1 write, 0 read
    sb_addr_t addr;   // byte offset inside the peripheral
    sb_data_t wdata;  // only meaningful when we is set
  } sb_req_t;

endpackage

// ==== logic/led_pkg.sv ====
`include "led_settings.svh"

package led_pkg;

  // one bit per LED pin
  typedef logic [`LED_COUNT-1:0] led_vec_t;

  // register offsets seen from the bus
  localparam logic [`SB_DATA_W-1:0] LED_VAL_OFFSET  = `LED_VAL_ADDR;   // led value
  localparam logic [`SB_DATA_W-1:0] LED_MODE_OFFSET = `LED_MODE_ADDR;  // blink mode
  localparam logic [`SB_DATA_W-1:0] LED_RST_OFFSET  = `LED_RST_ADDR;   // soft reset trigger

  // blink phases
  typedef enum logic {
    BLINK_SHOW = 1'b0,  // pins follow the led value
    BLINK_DARK = 1'b1   // pins forced low
  } blink_state_e;

endpackage

// ==== logic/led_sb_ctrl.sv ====
`timescale 1ns/100ps

`include "led_settings.svh"

module led_sb_ctrl (
  input  logic              clk_i,
  input  logic              rst_i,
  input  sb_pkg::sb_req_t   sb_req_i,
  output sb_pkg::sb_data_t  read_data_o,
  output led_pkg::led_vec_t led_val_o,
  output logic              blink_en_o,
  output logic              soft_rst_o
);

  import sb_pkg::*;
  import led_pkg::*;

  logic     wr_access;
  logic     rd_access;
  logic     hit_val;
  logic     hit_mode;
  logic     hit_rst;
  logic     val_legal;
  logic     mode_legal;
  logic     rst_legal;
  logic     val_we;
  logic     mode_we;
  logic     rd_hit;
  led_vec_t led_val_q;
  logic     mode_q;
  sb_data_t rdata_d;
  sb_data_t rdata_q;

  // request qualifiers
  assign wr_access = sb_req_i.req && sb_req_i.we;
  assign rd_access = sb_req_i.req && !sb_req_i.we;

  // offset decode
  assign hit_val  = (sb_req_i.addr == LED_VAL_OFFSET);
  assign hit_mode = (sb_req_i.addr == LED_MODE_OFFSET);
  assign hit_rst  = (sb_req_i.addr == LED_RST_OFFSET);

  // legal write data per register
  assign val_legal  = (sb_req_i.wdata[`SB_DATA_W-1:`LED_COUNT] == '0);  // upper half must be 0
  assign mode_legal = (sb_req_i.wdata[`SB_DATA_W-1:1] == '0);           // only 0 or 1
  assign rst_legal  = (sb_req_i.wdata == sb_data_t'(1));

  // pulse in the cycle of the write itself
  assign soft_rst_o = wr_access && hit_rst && rst_legal;

  assign val_we  = wr_access && hit_val && val_legal;
  assign mode_we = wr_access && hit_mode && mode_legal;

  // LED value register
  always_ff @(posedge clk_i) begin
    if (rst_i || soft_rst_o) begin
      led_val_q <= '0;
    end else if (val_we) begin
      led_val_q <= sb_req_i.wdata[`LED_COUNT-1:0];
    end
  end

  // blink mode register
  always_ff @(posedge clk_i) begin
    if (rst_i || soft_rst_o) begin
      mode_q <= 1'b0;
    end else if (mode_we) begin
      mode_q <= sb_req_i.wdata[0];
    end
  end

  // only these two offsets are readable
  assign rd_hit = rd_access && (hit_val || hit_mode);

  always_comb begin
    rdata_d = rdata_q;  // hold by default
    if (rd_hit) begin
      if (hit_mode) begin
        rdata_d = {{(`SB_DATA_W-1){1'b0}}, mode_q};
      end else begin
        rdata_d = {{(`SB_DATA_W-`LED_COUNT){1'b0}}, led_val_q};
      end
    end
  end

  // read data lands one clock after the read
  always_ff @(posedge clk_i) begin
    if (rst_i || soft_rst_o) begin
      rdata_q <= '0;
    end else begin
      rdata_q <= rdata_d;
    end
  end

  assign read_data_o = rdata_q;
  assign led_val_o   = led_val_q;
  assign blink_en_o  = mode_q;

endmodule

// ==== logic/blink_timer.sv ====
`timescale 1ns/100ps

`include "led_settings.svh"

module blink_timer (
  input  logic clk_i,
  input  logic rst_i,
  input  logic blink_en_i,
  input  logic soft_rst_i,
  output logic half_tick_o
);

  // wide enough for LED_BLINK_HALF-1 and at least one bit
  localparam int unsigned CNT_W =
    ($clog2(`LED_BLINK_HALF) > 0) ? $clog2(`LED_BLINK_HALF) : 1;

  typedef logic [CNT_W-1:0] half_cnt_t;

  localparam half_cnt_t CNT_LAST = half_cnt_t'(`LED_BLINK_HALF - 1);

  half_cnt_t cnt_q;
  logic      cnt_at_last;

  assign cnt_at_last = (cnt_q == CNT_LAST);

  // one cycle at the end of every half period
  assign half_tick_o = blink_en_i && cnt_at_last;

  always_ff @(posedge clk_i) begin
    if (rst_i || soft_rst_i || !blink_en_i) begin
      cnt_q <= '0;  // parked at 0 while steady
    end else if (cnt_at_last) begin
      cnt_q <= '0;  // wrap
    end else begin
      cnt_q <= cnt_q + half_cnt_t'(1);
    end
  end

endmodule

// ==== logic/blink_fsm.sv ====
`timescale 1ns/100ps

module blink_fsm (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              blink_en_i,
  input  logic              soft_rst_i,
  input  logic              half_tick_i,
  input  led_pkg::led_vec_t led_val_i,
  output led_pkg::led_vec_t led_o
);

  import led_pkg::*;

  blink_state_e state_q;
  blink_state_e state_d;

  // next state
  always_comb begin
    state_d = state_q;
    if (!blink_en_i) begin
      state_d = BLINK_SHOW;  // steady mode
    end else if (half_tick_i) begin
      case (state_q)
        BLINK_SHOW: state_d = BLINK_DARK;
        BLINK_DARK: state_d = BLINK_SHOW;
        default:    state_d = BLINK_SHOW;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || soft_rst_i) begin
      state_q <= BLINK_SHOW;
    end else begin
      state_q <= state_d;
    end
  end

  // pin drive follows the current phase
  always_comb begin
    case (state_q)
      BLINK_SHOW: led_o = led_val_i;
      BLINK_DARK: led_o = '0;
      default:    led_o = '0;
    endcase
  end

endmodule

// ==== logic/led_periph_top.sv ====
`timescale 1ns/100ps

module led_periph_top (
  input  logic              clk_i,
  input  logic              rst_i,
  input  sb_pkg::sb_req_t   sb_req_i,
  output sb_pkg::sb_data_t  read_data_o,
  output led_pkg::led_vec_t led_o
);

  import led_pkg::*;

  led_vec_t led_val;
  logic     blink_en;
  logic     soft_rst;
  logic     half_tick;

  // bus side registers
  led_sb_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .sb_req_i    (sb_req_i),
    .read_data_o (read_data_o),
    .led_val_o   (led_val),
    .blink_en_o  (blink_en),
    .soft_rst_o  (soft_rst)
  );

  // half period counter
  blink_timer u_timer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .blink_en_i  (blink_en),
    .soft_rst_i  (soft_rst),
    .half_tick_o (half_tick)
  );

  // show/dark phase and pin drive
  blink_fsm u_fsm (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .blink_en_i  (blink_en),
    .soft_rst_i  (soft_rst),
    .half_tick_i (half_tick),
    .led_val_i   (led_val),
    .led_o       (led_o)
  );

endmodule

// ==== tests/led_periph_assertions.sv ====
`timescale 1ns/100ps

module led_periph_assertions (
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  blink_en_i,
  input led_pkg::blink_state_e state_i,
  input led_pkg::led_vec_t     led_i
);

  import led_pkg::*;

  int unsigned err_cnt = 0;  // failed assertion attempts

  // pins must be dark in the dark phase
  dark_pins_low: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_i == BLINK_DARK) |-> (led_i == '0))
    else begin
      $error("LED pins driven during the dark phase");
      err_cnt++;
    end

  // registered state settles one edge after blinking stops
  steady_when_disabled: assert property (@(posedge clk_i) disable iff (rst_i)
    !blink_en_i |=> (state_i == BLINK_SHOW))
    else begin
      $error("blink state not BLINK_SHOW while blinking is disabled");
      err_cnt++;
    end

endmodule

bind blink_fsm led_periph_assertions u_assert (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .blink_en_i (blink_en_i),
  .state_i    (state_q),
  .led_i      (led_o)
);

// ==== tests/led_periph_checker.sv ====
`timescale 1ns/100ps

`include "led_settings.svh"

module led_periph_checker (
  input  logic              clk_i,
  input  sb_pkg::sb_data_t  read_data_i,
  input  led_pkg::led_vec_t led_i,
  input  logic              go_i,
  input  logic [8*24-1:0]   name_i,
  input  logic [8*8-1:0]    op_i,
  input  sb_pkg::sb_data_t  exp_i,
  output logic              done_o,
  output int unsigned       pass_cnt_o,
  output int unsigned       fail_cnt_o
);

  import sb_pkg::*;
  import led_pkg::*;

  localparam int unsigned WINDOW = 4 * `LED_BLINK_HALF;  // two full blink periods

  logic [8*24-1:0] cur_name;
  logic [8*8-1:0]  cur_op;
  sb_data_t        cur_exp;

  task automatic verify_read_data();
    if (read_data_i === cur_exp) begin
      $display("pass %0s", cur_name);
      pass_cnt_o++;
    end else begin
      $display("mismatch %0s: expected %h, actual %h", cur_name, cur_exp, read_data_i);
      fail_cnt_o++;
    end
  endtask

  task automatic compare_leds_now();
    led_vec_t want;
    want = cur_exp[`LED_COUNT-1:0];
    if (led_i === want) begin
      $display("pass %0s", cur_name);
      pass_cnt_o++;
    end else begin
      $display("mismatch %0s: expected %h, actual %h", cur_name, want, led_i);
      fail_cnt_o++;
    end
  endtask

  // samples led_i on WINDOW falling edges starting with the current one
  task automatic scan_led_window(input logic blinking);
    led_vec_t    want;
    led_vec_t    bad_want;
    led_vec_t    bad_got;
    int          bad_at;
    int unsigned lit;
    int unsigned dark;
    int          i;
    bad_at   = -1;
    bad_want = '0;
    bad_got  = '0;
    lit      = 0;
    dark     = 0;
    for (i = 0; i < WINDOW; i++) begin
      if (i > 0) begin
        @(negedge clk_i);
      end
      // lit in even half periods, dark in odd ones
      if (!blinking || ((i / `LED_BLINK_HALF) % 2 == 0)) begin
        want = cur_exp[`LED_COUNT-1:0];
      end else begin
        want = '0;
      end
      if (led_i === '0) begin
        dark++;
      end else begin
        lit++;
      end
      if (led_i !== want && bad_at < 0) begin
        bad_at   = i;
        bad_want = want;
        bad_got  = led_i;
      end
    end
    if (bad_at < 0) begin
      $display("pass %0s (lit %0d, dark %0d cycles)", cur_name, lit, dark);
      pass_cnt_o++;
    end else begin
      $display("mismatch %0s: expected %h, actual %h at window cycle %0d",
               cur_name, bad_want, bad_got, bad_at);
      fail_cnt_o++;
    end
  endtask

  initial begin
    done_o     = 1'b0;
    pass_cnt_o = 0;
    fail_cnt_o = 0;
    forever begin
      @(posedge clk_i);
      if (go_i === 1'b1) begin  // this edge takes the request
        cur_name = name_i;
        cur_op   = op_i;
        cur_exp  = exp_i;
        @(negedge clk_i);
        if (cur_op == "rd" || cur_op == "idle") begin
          verify_read_data();
        end else if (cur_op == "wr") begin
          compare_leds_now();
        end else if (cur_op == "blink") begin
          scan_led_window(1'b1);
        end else if (cur_op == "leds") begin
          scan_led_window(1'b0);
        end else begin
          $display("test %0s has an operation the checker does not know", cur_name);
          fail_cnt_o++;
        end
        done_o = 1'b1;
        @(negedge clk_i);
        done_o = 1'b0;
      end
    end
  end

endmodule

// ==== tests/led_periph_tb.sv ====
`timescale 1ns/100ps

`include "led_settings.svh"

module led_periph_tb;

  import sb_pkg::*;
  import led_pkg::*;

  localparam int unsigned DRIVE_SKEW   = 10;                         // ns after rising edge
  localparam int unsigned DONE_TIMEOUT = 4 * `LED_BLINK_HALF + 20;  // cycles
  localparam string       STIM_FILE    = "tests/led_periph_stim.txt";

  logic            clk;
  logic            rst;
  sb_req_t         sb_req;
  sb_data_t        read_data;
  led_vec_t        led;

  logic            chk_go;
  logic [8*24-1:0] chk_name;
  logic [8*8-1:0]  chk_op;
  sb_data_t        chk_exp;
  logic            chk_done;
  int unsigned     pass_cnt;
  int unsigned     fail_cnt;
  int unsigned     run_errors;

  led_periph_top u_dut (
    .clk_i       (clk),
    .rst_i       (rst),
    .sb_req_i    (sb_req),
    .read_data_o (read_data),
    .led_o       (led)
  );

  led_periph_checker u_checker (
    .clk_i       (clk),
    .read_data_i (read_data),
    .led_i       (led),
    .go_i        (chk_go),
    .name_i      (chk_name),
    .op_i        (chk_op),
    .exp_i       (chk_exp),
    .done_o      (chk_done),
    .pass_cnt_o  (pass_cnt),
    .fail_cnt_o  (fail_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // bus stays quiet but carries noise
  task automatic fill_idle();
    sb_req.req   = 1'b0;
    sb_req.we    = 1'($urandom);
    sb_req.addr  = sb_addr_t'($urandom);
    sb_req.wdata = sb_data_t'($urandom);
  endtask

  task automatic drive_step(input logic [8*24-1:0] name, input logic [8*8-1:0] op,
                            input sb_data_t addr, input sb_data_t data, input sb_data_t expv);
    @(posedge clk);
    #(DRIVE_SKEW);
    fill_idle();
    if (op == "rd") begin
      sb_req.req  = 1'b1;
      sb_req.we   = 1'b0;
      sb_req.addr = addr;
    end else if (op == "wr" || op == "blink") begin
      sb_req.req   = 1'b1;
      sb_req.we    = 1'b1;
      sb_req.addr  = addr;
      sb_req.wdata = data;
    end
    chk_name = name;
    chk_op   = op;
    chk_exp  = expv;
    chk_go   = 1'b1;
    @(posedge clk);
    #(DRIVE_SKEW);
    fill_idle();
    chk_go = 1'b0;
  endtask

  task automatic wait_for_checker(input logic [8*24-1:0] name, output logic ok);
    int unsigned cycles;
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < DONE_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      if (chk_done === 1'b1) begin
        ok = 1'b1;
      end
    end
    if (!ok) begin
      $display("test %0s: no result from the checker after %0d cycles", name, DONE_TIMEOUT);
    end
  endtask

  initial begin
    int              fd;
    int              n;
    string           line;
    logic [8*24-1:0] test_name;
    logic [8*8-1:0]  op;
    sb_data_t        addr;
    sb_data_t        data;
    sb_data_t        expv;
    logic            ok;
    logic            timed_out;
    int unsigned     assert_errs;
    rst        = 1'b1;
    sb_req     = '0;
    chk_go     = 1'b0;
    chk_name   = '0;
    chk_op     = '0;
    chk_exp    = '0;
    run_errors = 0;
    timed_out  = 1'b0;
    void'($urandom(32'hcc75_b51b));
    repeat (3) @(posedge clk);
    #(DRIVE_SKEW);
    rst = 1'b0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("could not open stimulus file %s", STIM_FILE);
      run_errors++;
    end else begin
      while (!timed_out && $fgets(line, fd) > 0) begin
        if (line.len() < 2 || line.getc(0) == "#") begin
          continue;  // blank or comment
        end
        n = $sscanf(line, "%s %s %h %h %h", test_name, op, addr, data, expv);
        if (n != 5) begin
          $display("malformed stimulus line: %s", line);
          run_errors++;
        end else if (!(op == "rd" || op == "wr" || op == "idle" || op == "blink" ||
                       op == "leds")) begin
          $display("test %0s uses an unknown operation", test_name);
          run_errors++;
        end else if (op == "blink" && addr != LED_MODE_OFFSET) begin
          $display("test %0s: a blink step must write the mode register", test_name);
          run_errors++;
        end else begin
          drive_step(test_name, op, addr, data, expv);
          wait_for_checker(test_name, ok);
          if (!ok) begin
            timed_out = 1'b1;
            run_errors++;
          end
        end
      end
      $fclose(fd);
    end
    repeat (2) @(posedge clk);
    assert_errs = u_dut.u_fsm.u_assert.err_cnt;
    $display("summary: %0d passed, %0d failed, %0d other errors, %0d assertion failures",
             pass_cnt, fail_cnt, run_errors, assert_errs);
    if (fail_cnt == 0 && run_errors == 0 && assert_errs == 0 && pass_cnt > 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/led_periph_stim.txt ====
# columns: test name, operation, address (hex), write data (hex), expected value (hex)
# rd and idle expect read_data_o, wr and leds expect led_o, blink expects the lit value
# after reset
reset_rd_val        rd     00000000 00000000 00000000
reset_rd_mode       rd     00000004 00000000 00000000
reset_leds_off      leds   00000000 00000000 00000000
# LED value register
val_wr_legal        wr     00000000 0000a5c3 0000a5c3
val_rd_legal        rd     00000000 00000000 0000a5c3
val_wr_upper_bit    wr     00000000 0001ffff 0000a5c3
val_rd_after_upper  rd     00000000 00000000 0000a5c3
val_wr_top_bit      wr     00000000 80001234 0000a5c3
val_rd_after_top    rd     00000000 00000000 0000a5c3
val_leds_steady     leds   00000000 00000000 0000a5c3
# read data holds over idle cycles, writes and unmapped reads
idle_holds_val      idle   00000000 00000000 0000a5c3
wr_holds_rdata      wr     00000000 00003c5a 00003c5a
idle_after_wr       idle   00000000 00000000 0000a5c3
rd_unmapped_holds   rd     00000024 00000000 0000a5c3
rd_val_new          rd     00000000 00000000 00003c5a
# mode register accepts only 0 and 1
mode_wr_two         wr     00000004 00000002 00003c5a
mode_rd_still_zero  rd     00000004 00000000 00000000
mode_wr_big         wr     00000004 ffffffff 00003c5a
mode_rd_after_big   rd     00000004 00000000 00000000
# blinking
blink_window        blink  00000004 00000001 00003c5a
mode_rd_one         rd     00000004 00000000 00000001
idle_holds_mode     idle   00000000 00000000 00000001
# soft reset while blinking
soft_rst_wr         wr     00000024 00000001 00000000
idle_rdata_cleared  idle   00000000 00000000 00000000
rst_rd_val          rd     00000000 00000000 00000000
rst_rd_mode         rd     00000004 00000000 00000000
rst_leds_off        leds   00000000 00000000 00000000
post_wr_val         wr     00000000 000000ff 000000ff
post_leds_steady    leds   00000000 00000000 000000ff
rst_wr_two          wr     00000024 00000002 000000ff
rst_rd_val_kept     rd     00000000 00000000 000000ff
rst_leds_kept       leds   00000000 00000000 000000ff

// ==== all.f ====
+incdir+logic
logic/sb_pkg.sv
logic/led_pkg.sv
logic/led_sb_ctrl.sv
logic/blink_timer.sv
logic/blink_fsm.sv
logic/led_periph_top.sv
tests/led_periph_assertions.sv
tests/led_periph_checker.sv
tests/led_periph_tb.sv

// ==== Bender.yml ====
package:
  name: led_periph

sources:
  - include_dirs:
      - logic
    files:
      - logic/sb_pkg.sv
      - logic/led_pkg.sv
      - logic/led_sb_ctrl.sv
      - logic/blink_timer.sv
      - logic/blink_fsm.sv
      - logic/led_periph_top.sv

  - target: tests
    include_dirs:
      - logic
    files:
      - tests/led_periph_assertions.sv
      - tests/led_periph_checker.sv
      - tests/led_periph_tb.sv
